// ==== compile.f ====
common/execPkg.sv
design/pipeReg.sv
decode/aluDecoder.sv
shift/operandShifter.sv
design/aluCore.sv
design/execUnit.sv
tests/execUnitTb.sv

// ==== Bender.yml ====
package:
  name: exec_unit

sources:
  - common/execPkg.sv
  - design/pipeReg.sv
  - decode/aluDecoder.sv
  - shift/operandShifter.sv
  - design/aluCore.sv
  - design/execUnit.sv
  - target: test
    files:
      - tests/execUnitTb.sv

// ==== tests/execUnitTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module execUnitTb import execPkg::*; ();

  logic        clk;
  logic        rstN;
  logic        opValid;
  execOp_t     opIn;
  logic        resValid;
  execResult_t res;
  flags_t      flags;

  logic [15:0] lfsrState;    // Fibonacci LFSR on x^16+x^14+x^13+x^11+1
  flags_t      modelFlags;   // Reference copy of stored NZCV
  execOp_t     opList[$];    // Ops waiting for the next stream
  int          checkErrors;
  int          timeouts;

  execUnit execUnit_inst (
    .clk      (clk),
    .rstN     (rstN),
    .opValid  (opValid),
    .opIn     (opIn),
    .resValid (resValid),
    .res      (res),
    .flags    (flags)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
  endfunction

  function automatic word_t randBits(input int nBits);
    word_t val;
    val = '0;
    for (int i = 0; i < nBits; i++) begin
      val = {val[DataWidth-2:0], lfsrBit()};  // One step per bit
    end
    return val;
  endfunction

  function automatic execOp_t makeOp(input opcode_t oc, input logic s, input word_t a,
                                     input word_t b, input shiftType_t st, input logic [4:0] amt);
    execOp_t op;
    op.opcode = oc;
    op.setFlags = s;
    op.a = a;
    op.b = b;
    op.shiftType = st;
    op.shiftAmount = amt;
    return op;
  endfunction

  // Model advances its flags only for flag-setting ops
  task automatic modelOp(input execOp_t op, inout flags_t f, output execResult_t exp);
    word_t sb, x, y, r;
    logic sc, isArith, isAdd, cin;
    logic [DataWidth:0] s;
    flags_t nf;
    int n;
    n = op.shiftAmount;
    sb = op.b;
    sc = f.c;  // Amount 0 keeps stored C
    if (n != 0) begin
      sc = op.b[n-1];  // Last bit out for right shifts and rotate
      case (op.shiftType)
        LSL: begin
          sb = op.b << n;
          sc = op.b[DataWidth-n];
        end
        LSR: sb = op.b >> n;
        ASR: sb = word_t'($signed(op.b) >>> n);
        default: sb = (op.b >> n) | (op.b << (DataWidth-n));
      endcase
    end
    nf = f;
    r = '0;
    x = op.a;
    y = sb;  // Second operand before complement
    cin = 1'b0;
    isArith = !(op.opcode inside {AND, TST, EOR, TEQ, ORR, BIC, MOV, MVN});
    isAdd = 1'b0;
    case (op.opcode)
      AND, TST: r = op.a & sb;
      EOR, TEQ: r = op.a ^ sb;
      ORR: r = op.a | sb;
      BIC: r = op.a & ~sb;
      MOV: r = sb;
      MVN: r = ~sb;
      ADD, CMN: isAdd = 1'b1;
      ADC: begin
        isAdd = 1'b1;
        cin = f.c;
      end
      SUB, CMP: cin = 1'b1;
      SBC: cin = f.c;
      RSB: begin  // Reversed subtract
        x = sb;
        y = op.a;
        cin = 1'b1;
      end
      default: begin  // RSC
        x = sb;
        y = op.a;
        cin = f.c;
      end
    endcase
    if (isArith) begin
      if (isAdd) s = {1'b0, x} + {1'b0, y} + cin;
      else s = {1'b0, x} + {1'b0, ~y} + cin;
      r = s[DataWidth-1:0];
      nf.c = s[DataWidth];
      if (isAdd) nf.v = (x[DataWidth-1] == y[DataWidth-1]) && (r[DataWidth-1] != x[DataWidth-1]);
      else nf.v = (x[DataWidth-1] != y[DataWidth-1]) && (r[DataWidth-1] != x[DataWidth-1]);
    end else begin
      nf.c = sc;  // V held for logic ops
    end
    nf.n = r[DataWidth-1];
    nf.z = (r == '0);
    if (op.setFlags) f = nf;
    exp.result = r;
    exp.writeReg = !(op.opcode == TST || op.opcode == TEQ || op.opcode == CMP || op.opcode == CMN);
    exp.flags = f;
  endtask

  task automatic checkResult(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
      checkErrors++;
    end
  endtask

  task automatic checkFlags(input string name, input flags_t exp, input flags_t act);
    if (exp !== act) begin
      $display("CHECK FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
      checkErrors++;
    end
  endtask

  task automatic checkWrite(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("CHECK FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
      checkErrors++;
    end
  endtask

  task automatic compareOutputs(input execResult_t exp);
    checkResult("res.result", exp.result, res.result);
    checkWrite("res.writeReg", exp.writeReg, res.writeReg);
    checkFlags("res.flags", exp.flags, res.flags);
    checkFlags("flags", exp.flags, flags);  // Stored flags already updated
  endtask

  // Drives opList back to back and compares results in order
  task automatic runStream();
    execResult_t expQ[$];
    execResult_t exp;
    int sent, idle;
    sent = 0;
    idle = 0;
    while ((sent < opList.size() || expQ.size() > 0) && idle < 10) begin
      if (sent < opList.size()) begin
        modelOp(opList[sent], modelFlags, exp);
        expQ.push_back(exp);
        opValid = 1'b1;
        opIn = opList[sent];
        sent++;
      end else begin
        opValid = 1'b0;
      end
      @(posedge clk);
      #2;
      if (resValid && expQ.size() == 0) begin
        $display("Unexpected result at t=%0t with no operation pending", $time);
        checkErrors++;
      end else if (resValid) begin
        compareOutputs(expQ.pop_front());
        idle = 0;
      end else begin
        idle++;
      end
    end
    opValid = 1'b0;
    if (expQ.size() > 0) begin
      $display("resValid never arrived");
      timeouts++;
    end
    opList.delete();
  endtask

  task automatic resetAndLatency();
    execOp_t op;
    execResult_t exp;
    int edges;
    checkWrite("resValid", 1'b0, resValid);
    checkResult("res.result", '0, res.result);
    checkWrite("res.writeReg", 1'b0, res.writeReg);
    checkFlags("res.flags", '0, res.flags);
    checkFlags("flags", '0, flags);
    op = makeOp(MOV, 1'b1, 32'h0, 32'h8000_0001, LSL, 5'd0);
    modelOp(op, modelFlags, exp);
    opValid = 1'b1;
    opIn = op;
    @(posedge clk);
    #2;
    opValid = 1'b0;
    edges = 1;
    while (!resValid && edges < 10) begin
      @(posedge clk);
      #2;
      edges++;
    end
    if (!resValid) begin
      $display("resValid never arrived");
      timeouts++;
    end else begin
      if (edges != 2) begin
        $display("resValid came %0d edges after the strobe instead of 2", edges);
        checkErrors++;
      end
      compareOutputs(exp);
      @(posedge clk);
      #2;
      checkWrite("resValid", 1'b0, resValid);  // Single cycle pulse
    end
  endtask

  task automatic logicalOps();
    opcode_t ops[6];
    ops = '{AND, EOR, ORR, BIC, MOV, MVN};
    opList.push_back(makeOp(ADD, 1'b1, 32'h7FFF_FFFF, 32'h1, LSL, 5'd0));  // Sets V first
    for (int i = 0; i < 6; i++) begin
      for (int st = 0; st < 4; st++) begin
        opList.push_back(makeOp(ops[i], 1'b1, randBits(32), randBits(32), shiftType_t'(st),
                                5'(randBits(5))));
      end
      opList.push_back(makeOp(ops[i], 1'b1, randBits(32), randBits(32),
                              shiftType_t'(randBits(2)), 5'd0));  // C from stored flag
    end
    runStream();
  endtask

  task automatic arithmeticOps();
    opcode_t ops[3];
    word_t same;
    ops = '{ADD, SUB, RSB};
    same = randBits(32);
    for (int i = 0; i < 9; i++) begin
      opList.push_back(makeOp(ops[i%3], 1'b1, randBits(32), randBits(32),
                              shiftType_t'(randBits(2)), 5'(randBits(5))));
    end
    opList.push_back(makeOp(ADD, 1'b1, 32'h7FFF_FFFF, 32'h1, LSL, 5'd0));  // Signed overflow
    opList.push_back(makeOp(ADD, 1'b1, 32'hFFFF_FFFF, 32'h1, LSL, 5'd0));  // Carry and zero
    opList.push_back(makeOp(SUB, 1'b1, 32'h0, 32'h1, LSL, 5'd0));          // Borrow
    opList.push_back(makeOp(SUB, 1'b1, same, same, LSL, 5'd0));
    opList.push_back(makeOp(RSB, 1'b1, same, same, LSL, 5'd0));
    opList.push_back(makeOp(SUB, 1'b1, 32'h8000_0000, 32'h1, LSL, 5'd0));  // Negative overflow
    runStream();
  endtask

  task automatic carryChain();
    opList.push_back(makeOp(ADD, 1'b1, 32'hFFFF_FFFF, 32'h1, LSL, 5'd0));  // C = 1
    opList.push_back(makeOp(ADC, 1'b1, randBits(32), randBits(32), LSL, 5'd0));
    opList.push_back(makeOp(SBC, 1'b1, randBits(32), randBits(32), LSR, 5'(randBits(5))));
    opList.push_back(makeOp(RSC, 1'b1, randBits(32), randBits(32), ROR, 5'(randBits(5))));
    opList.push_back(makeOp(ADD, 1'b1, 32'h1, 32'h1, LSL, 5'd0));          // C = 0
    opList.push_back(makeOp(ADC, 1'b1, 32'hFFFF_FFFE, 32'h1, LSL, 5'd0));
    opList.push_back(makeOp(SUB, 1'b1, 32'h3, 32'h5, LSL, 5'd0));          // Borrow clears C
    opList.push_back(makeOp(SBC, 1'b1, 32'h10, 32'h4, LSL, 5'd0));
    opList.push_back(makeOp(RSC, 1'b1, randBits(32), randBits(32), ASR, 5'(randBits(5))));
    opList.push_back(makeOp(ADC, 1'b0, randBits(32), randBits(32), LSL, 5'd0));  // Flags held
    opList.push_back(makeOp(SBC, 1'b1, randBits(32), randBits(32), LSL, 5'd0));
    runStream();
  endtask

  task automatic compareOps();
    word_t same;
    same = randBits(32);
    opList.push_back(makeOp(TST, 1'b1, randBits(32), randBits(32), LSL, 5'(randBits(5))));
    opList.push_back(makeOp(TEQ, 1'b1, same, same, LSL, 5'd0));            // Z set
    opList.push_back(makeOp(CMP, 1'b1, same, same, LSL, 5'd0));
    opList.push_back(makeOp(CMN, 1'b1, 32'h8000_0000, 32'h8000_0000, LSL, 5'd0));
    opList.push_back(makeOp(SUB, 1'b0, 32'h0, 32'h1, LSL, 5'd0));          // No flag update
    opList.push_back(makeOp(CMP, 1'b1, randBits(32), randBits(32), ASR, 5'(randBits(5))));
    opList.push_back(makeOp(TST, 1'b0, 32'h0, 32'h0, LSL, 5'd0));
    runStream();
  endtask

  task automatic randomStream();
    for (int i = 0; i < 40; i++) begin
      opList.push_back(makeOp(opcode_t'(randBits(4)), 1'(randBits(1)), randBits(32),
                              randBits(32), shiftType_t'(randBits(2)), 5'(randBits(5))));
    end
    runStream();
  endtask

  initial begin
    rstN = 1'b0;
    opValid = 1'b0;
    opIn = '0;
    lfsrState = 16'd20;
    modelFlags = '0;
    checkErrors = 0;
    timeouts = 0;
    repeat (10) @(posedge clk);  // Ten reset edges
    #2;
    rstN = 1'b1;
    resetAndLatency();
    logicalOps();
    arithmeticOps();
    carryChain();
    compareOps();
    randomStream();
    @(posedge clk);
    $display("Errors: %0d check, %0d timeout", checkErrors, timeouts);
    if (checkErrors == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/execUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module execUnit import execPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        opValid,
  input  execOp_t     opIn,
  output logic        resValid,
  output execResult_t res,
  output flags_t      flags
);

  logic        opValidQ;
  execOp_t     opQ;           // Registered operation
  aluCtrl_t    ctrl;
  word_t       shiftedB;
  logic        shifterCarry;
  execResult_t execRes;       // Unregistered result
  flags_t      flagsQ;        // Stored NZCV

  pipeReg #(.payload_t(execOp_t)) inStage (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (opValid),
    .inData   (opIn),
    .outValid (opValidQ),
    .outData  (opQ)
  );

  aluDecoder decoder (
    .opcode    (opQ.opcode),
    .prevFlags (flagsQ),
    .ctrl      (ctrl)
  );

  operandShifter shifter (
    .value       (opQ.b),
    .shiftType   (opQ.shiftType),
    .shiftAmount (opQ.shiftAmount),
    .prevCarry   (flagsQ.c),  // Used when amount is 0
    .shifted     (shiftedB),
    .carryOut    (shifterCarry)
  );

  aluCore core (
    .clk          (clk),
    .rstN         (rstN),
    .opValid      (opValidQ),
    .setFlags     (opQ.setFlags),
    .a            (opQ.a),
    .b            (shiftedB),
    .shifterCarry (shifterCarry),
    .ctrl         (ctrl),
    .execRes      (execRes),
    .flagsQ       (flagsQ)
  );

  pipeReg #(.payload_t(execResult_t)) outStage (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (opValidQ),
    .inData   (execRes),
    .outValid (resValid),
    .outData  (res)
  );

  assign flags = flagsQ;

endmodule

`default_nettype wire

// ==== design/aluCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module aluCore import execPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic        opValid,
  input  logic        setFlags,
  input  word_t       a,
  input  word_t       b,
  input  logic        shifterCarry,
  input  aluCtrl_t    ctrl,
  output execResult_t execRes,
  output flags_t      flagsQ
);

  word_t                opX;       // First adder operand
  word_t                opY;       // Second operand before invert
  word_t                addY;      // Second adder operand
  word_t                logicRes;
  word_t                result;
  logic [DataWidth:0]   sum;       // Carry out in MSB
  flags_t               flagsD;

  // Operand steering
  always_comb begin
    opX  = ctrl.reverseInputs ? b : a;  // RSB, RSC swap
    opY  = ctrl.reverseInputs ? a : b;
    addY = ctrl.invertB ? ~opY : opY;
  end

  assign sum = {1'b0, opX} + {1'b0, addY} + {{DataWidth{1'b0}}, ctrl.carryIn};

  always_comb begin
    unique case (ctrl.opClass)
      LOGIC_AND: logicRes = a & b;   // AND, TST
      LOGIC_EOR: logicRes = a ^ b;   // EOR, TEQ
      LOGIC_ORR: logicRes = a | b;
      LOGIC_BIC: logicRes = a & ~b;
      PASS_B:    logicRes = addY;    // MOV, or ~B for MVN
      default:   logicRes = '0;
    endcase
  end

  assign result = (ctrl.opClass == ARITH) ? sum[DataWidth-1:0] : logicRes;

  // NZCV from result and update mode
  always_comb begin
    flagsD.n = result[DataWidth-1];
    flagsD.z = (result == '0);
    unique case (ctrl.cvUpdate)
      ARITH_ADD: begin
        flagsD.c = sum[DataWidth];
        // Like signs in, other sign out
        flagsD.v = ~(opX[DataWidth-1] ^ opY[DataWidth-1])
                 & (opX[DataWidth-1] ^ sum[DataWidth-1]);
      end
      ARITH_SUB: begin
        flagsD.c = sum[DataWidth];  // C is not-borrow
        flagsD.v = (opX[DataWidth-1] ^ opY[DataWidth-1])
                 & (opX[DataWidth-1] ^ sum[DataWidth-1]);
      end
      default: begin
        flagsD.c = shifterCarry;  // Logical ops
        flagsD.v = flagsQ.v;
      end
    endcase
  end

  always_comb begin
    execRes.result   = result;
    execRes.writeReg = ~ctrl.doNotWriteReg;
    execRes.flags    = setFlags ? flagsD : flagsQ;  // Flags after this op
  end

  // Stored NZCV, next op reads it one cycle later
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flagsQ <= '0;
    end else if (opValid && setFlags) begin
      flagsQ <= flagsD;
    end
  end

endmodule

`default_nettype wire

// ==== shift/operandShifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module operandShifter import execPkg::*; (
  input  word_t      value,
  input  shiftType_t shiftType,
  input  logic [4:0] shiftAmount,
  input  logic       prevCarry,
  output word_t      shifted,
  output logic       carryOut
);

  logic        [DataWidth:0]     lslWide;  // Carry in top bit
  logic        [DataWidth:0]     lsrWide;  // Carry in bit 0
  logic signed [DataWidth:0]     asrWide;  // Carry in bit 0
  logic        [2*DataWidth-1:0] rorWide;  // Doubled word for rotate

  // Each shift carries one guard bit to catch the last bit out
  always_comb begin
    lslWide = {1'b0, value} << shiftAmount;
    lsrWide = {value, 1'b0} >> shiftAmount;
    asrWide = $signed({value, 1'b0}) >>> shiftAmount;  // Sign fill
    rorWide = {value, value} >> shiftAmount;
  end

  always_comb begin
    shifted  = value;  // Amount 0 passes through
    carryOut = prevCarry;  // and keeps stored C
    if (shiftAmount != '0) begin
      unique case (shiftType)
        LSL: begin
          shifted  = lslWide[DataWidth-1:0];
          carryOut = lslWide[DataWidth];  // value[32-n]
        end
        LSR: begin
          shifted  = lsrWide[DataWidth:1];
          carryOut = lsrWide[0];  // value[n-1]
        end
        ASR: begin
          shifted  = asrWide[DataWidth:1];
          carryOut = asrWide[0];
        end
        ROR: begin
          shifted  = rorWide[DataWidth-1:0];
          carryOut = rorWide[DataWidth-1];  // New MSB is last bit out
        end
        default: begin
          shifted  = value;
          carryOut = prevCarry;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== decode/aluDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module aluDecoder import execPkg::*; (
  input  opcode_t  opcode,
  input  flags_t   prevFlags,
  output aluCtrl_t ctrl
);

  always_comb begin
    ctrl = '0;  // Plain op, no invert, no swap, cin 0
    ctrl.opClass  = ARITH;
    ctrl.cvUpdate = KEEP_V_SHIFT_C;
    unique case (opcode)
      AND, TST: begin
        ctrl.opClass = LOGIC_AND;
      end
      EOR, TEQ: begin
        ctrl.opClass = LOGIC_EOR;
      end
      SUB, CMP: begin  // A + ~B + 1
        ctrl.invertB  = 1'b1;
        ctrl.carryIn  = 1'b1;
        ctrl.cvUpdate = ARITH_SUB;
      end
      RSB: begin  // B + ~A + 1
        ctrl.invertB       = 1'b1;
        ctrl.reverseInputs = 1'b1;
        ctrl.carryIn       = 1'b1;
        ctrl.cvUpdate      = ARITH_SUB;
      end
      ADD, CMN: begin
        ctrl.cvUpdate = ARITH_ADD;
      end
      ADC: begin
        ctrl.carryIn  = prevFlags.c;  // Stored C chains in
        ctrl.cvUpdate = ARITH_ADD;
      end
      SBC: begin
        ctrl.invertB  = 1'b1;
        ctrl.carryIn  = prevFlags.c;  // Borrow is ~C
        ctrl.cvUpdate = ARITH_SUB;
      end
      RSC: begin
        ctrl.invertB       = 1'b1;
        ctrl.reverseInputs = 1'b1;
        ctrl.carryIn       = prevFlags.c;
        ctrl.cvUpdate      = ARITH_SUB;
      end
      ORR: begin
        ctrl.opClass = LOGIC_ORR;
      end
      MOV: begin
        ctrl.opClass = PASS_B;
      end
      BIC: begin
        ctrl.opClass = LOGIC_BIC;
      end
      MVN: begin
        ctrl.opClass = PASS_B;
        ctrl.invertB = 1'b1;  // Pass ~B
      end
      default: begin
        ctrl.opClass = ARITH;
      end
    endcase

    // Test and compare group only updates flags
    ctrl.doNotWriteReg = (opcode inside {TST, TEQ, CMP, CMN});
  end

endmodule

`default_nettype wire

// ==== design/pipeReg.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipeReg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rstN,
  input  logic     inValid,
  input  payload_t inData,
  output logic     outValid,
  output payload_t outData
);

  // One stage, no stall, both fields load every edge
  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
      outData  <= '0;  // Keeps res at zero after reset
    end else begin
      outValid <= inValid;
      outData  <= inData;
    end
  end

endmodule

`default_nettype wire

// ==== common/execPkg.sv ====
`default_nettype none

package execPkg;

  localparam int DataWidth = 32;  // Datapath width, sign bit at DataWidth-1

  typedef logic [DataWidth-1:0] word_t;

  // Data-processing opcodes, instruction bits 24:21
  typedef enum logic [3:0] {
    AND, EOR, SUB, RSB, ADD, ADC, SBC, RSC,
    TST, TEQ, CMP, CMN, ORR, MOV, BIC, MVN
  } opcode_t;

  typedef enum logic [1:0] {LSL, LSR, ASR, ROR} shiftType_t;

  typedef struct packed {
    logic n;  // Negative
    logic z;  // Zero
    logic c;  // Carry
    logic v;  // Overflow
  } flags_t;

  typedef enum logic [2:0] {
    LOGIC_AND, LOGIC_EOR, LOGIC_ORR, LOGIC_BIC, PASS_B, ARITH
  } aluOpClass_t;

  typedef enum logic [1:0] {
    KEEP_V_SHIFT_C,  // C from shifter, V held
    ARITH_ADD,       // Add overflow rule
    ARITH_SUB        // Subtract overflow rule
  } cvUpdate_t;

  typedef struct packed {
    aluOpClass_t opClass;
    logic        invertB;        // Complement second adder operand
    logic        reverseInputs;  // Swap A and B before the adder
    logic        carryIn;
    logic        doNotWriteReg;  // Compare ops, flags only
    cvUpdate_t   cvUpdate;
  } aluCtrl_t;

  typedef struct packed {
    opcode_t    opcode;
    logic       setFlags;
    word_t      a;
    word_t      b;            // Unshifted operand B
    shiftType_t shiftType;
    logic [4:0] shiftAmount;
  } execOp_t;

  typedef struct packed {
    word_t  result;
    logic   writeReg;
    flags_t flags;  // Flags as left by this op
  } execResult_t;

endpackage

`default_nettype wire
